// ==== verilog.f ====
hdl/ssm_pkg.sv
hdl/st_host_regs.sv
hdl/ss_sys_regs.sv
hdl/cdc_regs.sv
hdl/cdc_fifo.sv
hdl/ss_read_port.sv
hdl/ssmaster_core.sv
tb/ssm_checker.sv
tb/tb_ssmaster.sv

// ==== Bender.yml ====
package:
  name: ssmaster_core

sources:
  - hdl/ssm_pkg.sv
  - hdl/st_host_regs.sv
  - hdl/ss_sys_regs.sv
  - hdl/cdc_regs.sv
  - hdl/cdc_fifo.sv
  - hdl/ss_read_port.sv
  - hdl/ssmaster_core.sv
  - target: test
    files:
      - tb/ssm_checker.sv
      - tb/tb_ssmaster.sv

// ==== tb/tb_ssmaster.sv ====
/*
 * Directed and random tests of the bridge core against a shadow register model.
 * Bus strobes are driven 5 units after the rising edge, one op at a time.
 * Timer low word and FIFO reads while empty are not predicted.
 */
`default_nettype none

module tb_ssmaster;
	import ssm_pkg::*;

	localparam int DLY        = 5;
	localparam int FIFO_WORDS = 300;
	// Five cycles per FIFO word plus 500 for the register tests, doubled
	localparam int CYCLE_LIMIT = 2 * (FIFO_WORDS * 5 + 500);
	localparam logic [1:0] K_ST    = 2'd0;
	localparam logic [1:0] K_SS    = 2'd1;
	localparam logic [1:0] K_STIRQ = 2'd2;
	localparam logic [1:0] K_SSIRQ = 2'd3;

	logic              mclk;
	logic              st_ale;
	st_bus_t           st_bus;
	ss_bus_t           ss_bus;
	logic [DATA_W-1:0] st_rdata;
	logic [DATA_W-1:0] ss_rdata;
	logic              st_irq;
	logic              ss_irq;
	logic              chk_valid;
	logic [1:0]        chk_kind;
	logic [DATA_W-1:0] chk_exp;
	logic [8*16-1:0]   chk_name;
	int                chk_count;
	int                err_count;
	int                cycle_cnt = 0;
	int                seed = 32;
	int                n;

	// Shadow model of the register map
	logic [DATA_W-1:0]      m_ctrl;
	logic [2:0]             m_flags;
	logic                   m_pending;
	logic [DATA_W-1:0]      m_sys_ctrl;
	logic [DATA_W-1:0]      m_cmd;
	logic [DATA_W-1:0]      m_data;
	logic [DATA_W-1:0]      m_hirq;
	logic [DATA_W-1:0]      m_mask;
	logic [3:0][DATA_W-1:0] m_cr;
	logic [3:0][DATA_W-1:0] m_resp;
	logic [DATA_W-1:0]      m_fifo[$];

	ssmaster_core u_dut (
		.mclk     (mclk),
		.st_ale   (st_ale),
		.st_bus   (st_bus),
		.ss_bus   (ss_bus),
		.st_rdata (st_rdata),
		.ss_rdata (ss_rdata),
		.st_irq   (st_irq),
		.ss_irq   (ss_irq)
	);

	ssm_checker u_checker (
		.mclk      (mclk),
		.st_rdata  (st_rdata),
		.ss_rdata  (ss_rdata),
		.st_irq    (st_irq),
		.ss_irq    (ss_irq),
		.chk_valid (chk_valid),
		.chk_kind  (chk_kind),
		.chk_exp   (chk_exp),
		.chk_name  (chk_name),
		.chk_count (chk_count),
		.err_count (err_count)
	);

	initial
	begin
		mclk = 1'b0;
		forever #20 mclk = ~mclk;
	end

	always @(posedge mclk)
		cycle_cnt <= cycle_cnt + 1;

	initial
	begin
		wait (cycle_cnt >= CYCLE_LIMIT);
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test FAILED");
		$finish;
	end

	////////////////////
	// Reference model
	////////////////////

	function automatic logic model_st_irq();
		return |(m_flags & m_ctrl[2:0]);
	endfunction

	// Full flag above the 11-bit count
	function automatic logic [DATA_W-1:0] fill_word();
		int size;
		size = m_fifo.size();
		return (16'(size == FIFO_DEPTH) << 11) | 16'(size);
	endfunction

	function automatic logic [DATA_W-1:0] swapped_head();
		logic [DATA_W-1:0] head;
		head = (m_fifo.size() > 0) ? m_fifo[0] : '0;
		return {head[7:0], head[15:8]};
	endfunction

	function automatic logic [DATA_W-1:0] exp_st_read(input logic [7:0] addr);
		case (addr)
			ST_ID:        return ID_WORD;
			ST_VER:       return VERSION_WORD;
			ST_CTRL:      return m_ctrl;
			ST_STAT:
				return (16'(model_st_irq()) << 14) | (16'(m_pending) << 12) | 16'(m_flags);
			ST_FIFO_STAT: return fill_word();
			ST_SS_CMD:    return m_cmd;
			ST_SS_DATA:   return m_data;
			ST_SS_CTRL:   return m_sys_ctrl;
			ST_RESP1:     return m_resp[0];
			ST_RESP2:     return m_resp[1];
			ST_RESP3:     return m_resp[2];
			ST_RESP4:     return m_resp[3];
			ST_CR1:       return m_cr[0];
			ST_CR2:       return m_cr[1];
			ST_CR3:       return m_cr[2];
			ST_CR4:       return m_cr[3];
			ST_HIRQ:      return m_hirq;
			ST_HIRQ_MASK: return m_mask;
			default:      return 16'hFFFF;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] exp_ss_read(input ss_region_e region,
		input logic [4:0] hidx);
		logic [3:0] widx;
		widx = hidx[4:1];
		if (region == SS_SYS)
		begin
			case (widx)
				SYS_ID:    return hidx[0] ? VERSION_WORD : ID_WORD;
				SYS_CTRL:  return m_sys_ctrl;
				SYS_STAT:  return fill_word();
				// Only the high word just after a clear is known
				SYS_TIMER: return '0;
				SYS_CMD:   return m_cmd;
				SYS_DATA:  return m_data;
				SYS_FIFO:  return swapped_head();
				default:   return '0;
			endcase
		end
		else if (region == SS_CDC)
		begin
			case (widx)
				CDC_FIFO: return swapped_head();
				CDC_HIRQ: return m_hirq;
				CDC_MASK: return m_mask;
				CDC_CR1:  return m_resp[0];
				CDC_CR2:  return m_resp[1];
				CDC_CR3:  return m_resp[2];
				CDC_CR4:  return m_resp[3];
				default:  return '0;
			endcase
		end
		return '0;
	endfunction

	// Drain event on 256 to 255 and on reaching empty
	task automatic model_pop();
		int old;
		old = m_fifo.size();
		if (old > 0)
		begin
			void'(m_fifo.pop_front());
			if (old == DRAIN_LEVEL || old == 1)
				m_flags[2] = 1'b1;
		end
	endtask

	////////////////////
	// Bus tasks
	////////////////////

	task automatic idle(input int cycles);
		repeat (cycles) @(posedge mclk);
	endtask

	// Called at edge plus DLY, holds the request for one edge
	task automatic request_check(input logic [1:0] kind, input logic [DATA_W-1:0] exp,
		input logic [8*16-1:0] name);
		chk_valid = 1'b1;
		chk_kind  = kind;
		chk_exp   = exp;
		chk_name  = name;
		@(posedge mclk);
		#DLY;
		chk_valid = 1'b0;
	endtask

	task automatic irq_check(input logic [1:0] kind, input logic [8*16-1:0] name);
		logic [DATA_W-1:0] exp;
		exp = (kind == K_STIRQ) ? 16'(model_st_irq()) : 16'(|(m_hirq & m_mask));
		@(posedge mclk);
		#DLY;
		request_check(kind, exp, name);
	endtask

	task automatic st_write(input logic [7:0] addr, input logic [DATA_W-1:0] data);
		@(posedge mclk);
		#DLY;
		st_bus.wr    = 1'b1;
		st_bus.addr  = addr;
		st_bus.wdata = data;
		case (addr)
			ST_CTRL:
			begin
				m_ctrl = data;
				// Clearing a filled FIFO also fires the drain event
				if (data[8] && m_fifo.size() > 0)
				begin
					m_fifo.delete();
					m_flags[2] = 1'b1;
				end
			end
			ST_STAT:     m_flags = m_flags & ~data[2:0];
			ST_FIFO_WR:
				if (m_fifo.size() < FIFO_DEPTH && !m_ctrl[8])
					m_fifo.push_back(data);
			ST_SS_CMD:   m_cmd = '0;
			ST_SS_DATA:  m_data = data;
			ST_CR1:      m_resp[0] = data;
			ST_CR2:      m_resp[1] = data;
			ST_CR3:      m_resp[2] = data;
			ST_CR4:      m_resp[3] = data;
			ST_HIRQ:     m_hirq = m_hirq | data;
			ST_HIRQ_CLR: m_hirq = m_hirq & ~data;
			default:     ;
		endcase
		@(posedge mclk);
		#DLY;
		st_bus.wr = 1'b0;
	endtask

	task automatic ss_write(input ss_region_e region, input logic [4:0] hidx,
		input logic [DATA_W-1:0] data);
		@(posedge mclk);
		#DLY;
		ss_bus.wr     = 1'b1;
		ss_bus.region = region;
		ss_bus.hidx   = hidx;
		ss_bus.wdata  = data;
		if (region == SS_SYS)
		begin
			case (hidx[4:1])
				SYS_CTRL: m_sys_ctrl = data;
				SYS_CMD:
				begin
					m_cmd      = data;
					m_flags[1] = 1'b1;
				end
				SYS_DATA: m_data = data;
				default:  ;
			endcase
		end
		else if (region == SS_CDC)
		begin
			case (hidx[4:1])
				CDC_HIRQ: m_hirq = m_hirq & data;
				CDC_MASK: m_mask = data;
				CDC_CR1:  m_cr[0] = data;
				CDC_CR2:  m_cr[1] = data;
				CDC_CR3:  m_cr[2] = data;
				CDC_CR4:
				begin
					m_cr[3]    = data;
					m_pending  = 1'b1;
					m_flags[0] = 1'b1;
				end
				default:  ;
			endcase
		end
		@(posedge mclk);
		#DLY;
		ss_bus.wr = 1'b0;
	endtask

	task automatic st_read(input logic [7:0] addr, input logic [8*16-1:0] name);
		logic [DATA_W-1:0] exp;
		exp = exp_st_read(addr);
		@(posedge mclk);
		#DLY;
		st_bus.rd   = 1'b1;
		st_bus.addr = addr;
		@(posedge mclk);
		#DLY;
		st_bus.rd = 1'b0;
		request_check(K_ST, exp, name);
	endtask

	task automatic ss_read(input ss_region_e region, input logic [4:0] hidx,
		input logic [8*16-1:0] name);
		logic [DATA_W-1:0] exp;
		exp = exp_ss_read(region, hidx);
		// Side effects of the read
		if ((region == SS_SYS && hidx[4:1] == SYS_FIFO) ||
			(region == SS_CDC && hidx[4:1] == CDC_FIFO))
			model_pop();
		if (region == SS_CDC && hidx[4:1] == CDC_CR4)
			m_pending = 1'b0;
		@(posedge mclk);
		#DLY;
		ss_bus.rd     = 1'b1;
		ss_bus.region = region;
		ss_bus.hidx   = hidx;
		@(posedge mclk);
		#DLY;
		ss_bus.rd = 1'b0;
		request_check(K_SS, exp, name);
	endtask

	task automatic hirq_check(input logic [8*16-1:0] name);
		st_read(ST_HIRQ, name);
		ss_read(SS_CDC, {CDC_HIRQ, 1'b0}, name);
		irq_check(K_SSIRQ, "ss irq");
	endtask

	// Odd words from the CDC window, even words from the system window
	task automatic pop_word(input int idx);
		if (idx % 2)
			ss_read(SS_CDC, {CDC_FIFO, 1'b0}, "fifo pop cdc");
		else
			ss_read(SS_SYS, {SYS_FIFO, 1'b0}, "fifo pop sys");
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial
	begin
		st_ale     = 1'b1;
		st_bus     = '0;
		ss_bus     = '0;
		chk_valid  = 1'b0;
		chk_kind   = K_ST;
		chk_exp    = '0;
		chk_name   = '0;
		m_ctrl     = '0;
		m_flags    = '0;
		m_pending  = 1'b0;
		m_sys_ctrl = SYS_CTRL_RESET;
		m_cmd      = '0;
		m_data     = '0;
		m_hirq     = '0;
		m_mask     = '0;
		m_cr       = '0;
		m_resp     = '0;
		repeat (2) @(posedge mclk);
		#DLY;
		st_ale = 1'b0;

		// Reset values
		st_read(ST_ID, "host id");
		st_read(ST_VER, "host version");
		ss_read(SS_SYS, 5'd0, "console id");
		ss_read(SS_SYS, 5'd1, "console version");
		st_read(ST_SS_CTRL, "host ss ctrl");
		ss_read(SS_SYS, {SYS_CTRL, 1'b0}, "console ctrl");
		st_read(8'h30, "unmapped");
		irq_check(K_STIRQ, "reset st irq");
		irq_check(K_SSIRQ, "reset ss irq");

		// Command mailbox and shared data
		st_write(ST_CTRL, 16'h0002);
		ss_write(SS_SYS, {SYS_CMD, 1'b0}, 16'($random(seed)));
		st_read(ST_SS_CMD, "cmd mailbox");
		irq_check(K_STIRQ, "cmd irq");
		st_read(ST_STAT, "cmd stat");
		st_write(ST_STAT, 16'h0002);
		irq_check(K_STIRQ, "cmd irq ack");
		st_write(ST_SS_CMD, 16'h0000);
		st_read(ST_SS_CMD, "cmd cleared");
		ss_read(SS_SYS, {SYS_CMD, 1'b0}, "ss cmd cleared");
		st_write(ST_SS_DATA, 16'($random(seed)));
		ss_read(SS_SYS, {SYS_DATA, 1'b0}, "data host wr");
		st_read(ST_SS_DATA, "data host wr");
		ss_write(SS_SYS, {SYS_DATA, 1'b0}, 16'($random(seed)));
		st_read(ST_SS_DATA, "data ss wr");
		ss_read(SS_SYS, {SYS_DATA, 1'b0}, "data ss wr");

		// CDC command and responses
		st_write(ST_CTRL, 16'h0001);
		for (n = 0; n < 4; n++)
			ss_write(SS_CDC, {4'(CDC_CR1 + n), 1'b0}, 16'($random(seed)));
		for (n = 0; n < 4; n++)
			st_read(8'(ST_CR1 + 2 * n), "cr readback");
		st_read(ST_STAT, "cdc stat");
		irq_check(K_STIRQ, "cdc irq");
		for (n = 0; n < 4; n++)
		begin
			st_write(8'(ST_CR1 + 2 * n), 16'($random(seed)));
			st_read(8'(ST_RESP1 + 2 * n), "resp readback");
		end
		for (n = 0; n < 4; n++)
			ss_read(SS_CDC, {4'(CDC_CR1 + n), 1'b0}, "cr response");
		st_read(ST_STAT, "pending cleared");
		st_write(ST_STAT, 16'h0001);

		// HIRQ set, clear and console AND
		ss_write(SS_CDC, {CDC_MASK, 1'b0}, 16'($random(seed)));
		st_read(ST_HIRQ_MASK, "hirq mask");
		for (n = 0; n < 4; n++)
		begin
			st_write(ST_HIRQ, 16'($random(seed)));
			hirq_check("hirq set");
			st_write(ST_HIRQ_CLR, 16'($random(seed)));
			hirq_check("hirq clear");
			ss_write(SS_CDC, {CDC_HIRQ, 1'b0}, 16'($random(seed)));
			hirq_check("hirq and");
		end
		ss_write(SS_CDC, {CDC_HIRQ, 1'b0}, 16'h0000);
		hirq_check("hirq zero");

		// FIFO fill, drain crossing and empty
		st_write(ST_CTRL, 16'h0004);
		for (n = 0; n < FIFO_WORDS; n++)
			st_write(ST_FIFO_WR, 16'($random(seed)));
		st_read(ST_FIFO_STAT, "fill count");
		ss_read(SS_SYS, {SYS_STAT, 1'b0}, "ss fill count");
		for (n = 0; n < FIFO_WORDS - DRAIN_LEVEL + 1; n++)
			pop_word(n);
		idle(4);
		st_read(ST_STAT, "drain flag");
		irq_check(K_STIRQ, "drain irq");
		st_write(ST_STAT, 16'h0004);
		st_read(ST_STAT, "drain flag ack");
		for (n = FIFO_WORDS - DRAIN_LEVEL + 1; n < FIFO_WORDS; n++)
			pop_word(n);
		idle(4);
		st_read(ST_STAT, "empty flag");
		st_read(ST_FIFO_STAT, "empty count");
		st_write(ST_STAT, 16'h0004);

		// FIFO clear by control bit 8, then timer
		for (n = 0; n < 8; n++)
			st_write(ST_FIFO_WR, 16'($random(seed)));
		st_read(ST_FIFO_STAT, "refill count");
		st_write(ST_CTRL, 16'h0104);
		st_write(ST_CTRL, 16'h0004);
		st_read(ST_FIFO_STAT, "fifo cleared");
		idle(2);
		st_read(ST_STAT, "clear drain");
		st_write(ST_STAT, 16'h0004);
		ss_write(SS_SYS, {SYS_TIMER, 1'b0}, 16'h0000);
		ss_read(SS_SYS, {SYS_TIMER, 1'b0}, "timer high");

		idle(2);
		$display("Checks: %0d, errors: %0d", chk_count, err_count);
		if (err_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/ssm_checker.sv ====
/*
 * Watches the DUT read data and irqs and compares them with the testbench model.
 * A check is taken at each rising edge while chk_valid is high.
 * Counts are read by the testbench top at the end of the run.
 */
`default_nettype none

module ssm_checker (
	input  logic                        mclk,
	input  logic [ssm_pkg::DATA_W-1:0]  st_rdata,
	input  logic [ssm_pkg::DATA_W-1:0]  ss_rdata,
	input  logic                        st_irq,
	input  logic                        ss_irq,
	input  logic                        chk_valid,
	input  logic [1:0]                  chk_kind,
	input  logic [ssm_pkg::DATA_W-1:0]  chk_exp,
	input  logic [8*16-1:0]             chk_name,
	output int                          chk_count,
	output int                          err_count
);
	import ssm_pkg::*;

	logic [DATA_W-1:0] actual;

	// Kind 0 host read, 1 console read, 2 host irq, 3 console irq
	always_comb
	begin
		case (chk_kind)
			2'd0:    actual = st_rdata;
			2'd1:    actual = ss_rdata;
			2'd2:    actual = {15'b0, st_irq};
			default: actual = {15'b0, ss_irq};
		endcase
	end

	initial
	begin
		chk_count = 0;
		err_count = 0;
	end

	// Read words hold until the next read, so the edge sample is stable
	always @(posedge mclk)
	begin
		if (chk_valid)
		begin
			chk_count = chk_count + 1;
			if (actual !== chk_exp)
			begin
				err_count = err_count + 1;
				$display("Error: %0s expected %h actual %h at %0t",
					chk_name, chk_exp, actual, $time);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ssmaster_core.sv ====
/*
 * Register and mailbox core of the cartridge bridge.
 * Both bus inputs are single-cycle strobes on mclk, st_ale resets everything.
 */
`default_nettype none

module ssmaster_core (
	input  logic                          mclk,
	input  logic                          st_ale,
	input  ssm_pkg::st_bus_t              st_bus,
	input  ssm_pkg::ss_bus_t              ss_bus,
	output logic [ssm_pkg::DATA_W-1:0]    st_rdata,
	output logic [ssm_pkg::DATA_W-1:0]    ss_rdata,
	output logic                          st_irq,
	output logic                          ss_irq
);
	import ssm_pkg::*;

	sys_view_t              sys_view;
	cdc_view_t              cdc_view;
	logic [USEDW_W-1:0]     fifo_usedw;
	logic                   fifo_full;
	logic                   fifo_drain;
	logic                   fifo_clear;
	logic                   fifo_pop;
	logic [DATA_W-1:0]      fifo_q;
	logic                   cmd_event;
	logic                   cr4_event;
	logic [3:0][DATA_W-1:0] resp;
	logic [DATA_W-1:0]      sys_rdata;
	logic [DATA_W-1:0]      cdc_rdata;

	////////////////////
	// Host side
	////////////////////

	st_host_regs u_host (
		.mclk       (mclk),
		.st_ale     (st_ale),
		.st_bus     (st_bus),
		.sys_view   (sys_view),
		.cdc_view   (cdc_view),
		.fifo_usedw (fifo_usedw),
		.fifo_full  (fifo_full),
		.fifo_drain (fifo_drain),
		.cmd_event  (cmd_event),
		.cr4_event  (cr4_event),
		.st_rdata   (st_rdata),
		.st_irq     (st_irq),
		.resp       (resp),
		.fifo_clear (fifo_clear)
	);

	////////////////////
	// Console side
	////////////////////

	ss_sys_regs u_sys (
		.mclk       (mclk),
		.st_ale     (st_ale),
		.ss_bus     (ss_bus),
		.st_bus     (st_bus),
		.fifo_usedw (fifo_usedw),
		.fifo_full  (fifo_full),
		.sys_view   (sys_view),
		.sys_rdata  (sys_rdata),
		.cmd_event  (cmd_event)
	);

	cdc_regs u_cdc (
		.mclk      (mclk),
		.st_ale    (st_ale),
		.ss_bus    (ss_bus),
		.st_bus    (st_bus),
		.resp      (resp),
		.cdc_view  (cdc_view),
		.cdc_rdata (cdc_rdata),
		.cr4_event (cr4_event),
		.ss_irq    (ss_irq)
	);

	// Empty flag only matters inside the FIFO
	cdc_fifo u_fifo (
		.mclk       (mclk),
		.st_ale     (st_ale),
		.fifo_clear (fifo_clear),
		.st_bus     (st_bus),
		.pop        (fifo_pop),
		.q          (fifo_q),
		.usedw      (fifo_usedw),
		.empty      (),
		.full       (fifo_full),
		.drain      (fifo_drain)
	);

	ss_read_port u_rdport (
		.mclk      (mclk),
		.ss_bus    (ss_bus),
		.sys_rdata (sys_rdata),
		.cdc_rdata (cdc_rdata),
		.fifo_q    (fifo_q),
		.ss_rdata  (ss_rdata),
		.fifo_pop  (fifo_pop)
	);

endmodule

`default_nettype wire

// ==== hdl/ss_read_port.sv ====
/*
 * Console read port: FIFO window decode and the registered read word.
 * FIFO words go out byte swapped for the big-endian console.
 */
`default_nettype none

module ss_read_port (
	input  logic                          mclk,
	input  ssm_pkg::ss_bus_t              ss_bus,
	input  logic [ssm_pkg::DATA_W-1:0]    sys_rdata,
	input  logic [ssm_pkg::DATA_W-1:0]    cdc_rdata,
	input  logic [ssm_pkg::DATA_W-1:0]    fifo_q,
	output logic [ssm_pkg::DATA_W-1:0]    ss_rdata,
	output logic                          fifo_pop
);
	import ssm_pkg::*;

	logic [3:0] widx;
	logic       fifo_win;

	assign widx = ss_bus.hidx[4:1];

	// Two windows onto the same FIFO
	assign fifo_win = (ss_bus.region == SS_SYS && widx == SYS_FIFO) ||
		(ss_bus.region == SS_CDC && widx == CDC_FIFO);
	assign fifo_pop = ss_bus.rd && fifo_win;

	// Head word of the strobe cycle is captured with the pop
	always_ff @(posedge mclk)
	begin
		if (ss_bus.rd)
		begin
			if (fifo_win)
				ss_rdata <= {fifo_q[7:0], fifo_q[15:8]};
			else
			begin
				case (ss_bus.region)
					SS_SYS:  ss_rdata <= sys_rdata;
					SS_CDC:  ss_rdata <= cdc_rdata;
					SS_NONE: ss_rdata <= '0;
					default: ss_rdata <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cdc_fifo.sv ====
/*
 * Host-to-console data FIFO, 1024 words, head word always on q.
 * Push while full and pop while empty are dropped.
 * drain pulses one cycle after the count leaves DRAIN_LEVEL or hits zero.
 */
`default_nettype none

module cdc_fifo (
	input  logic                          mclk,
	input  logic                          st_ale,
	input  logic                          fifo_clear,
	input  ssm_pkg::st_bus_t              st_bus,
	input  logic                          pop,
	output logic [ssm_pkg::DATA_W-1:0]    q,
	output logic [ssm_pkg::USEDW_W-1:0]   usedw,
	output logic                          empty,
	output logic                          full,
	output logic                          drain
);
	import ssm_pkg::*;

	logic [DATA_W-1:0]  mem [FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [USEDW_W-1:0] usedw_d;
	logic               wr_req;
	logic               push;
	logic               do_pop;

	assign wr_req = st_bus.wr && (st_bus.addr == ST_FIFO_WR);
	assign push   = wr_req && !full;
	assign do_pop = pop && !empty;
	assign empty  = (usedw == '0);
	assign full   = (usedw == USEDW_W'(FIFO_DEPTH));
	assign q      = mem[rd_ptr];

	always_ff @(posedge mclk)
	begin
		if (push)
			mem[wr_ptr] <= st_bus.wdata;
	end

	////////////////////
	// Pointers and count
	////////////////////

	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			usedw  <= '0;
		end
		else if (fifo_clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			usedw  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10:   usedw <= usedw + 1'b1;
				2'b01:   usedw <= usedw - 1'b1;
				default: ;
			endcase
		end
	end

	// Count moves by one at most, so equality catches the crossing
	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
		begin
			usedw_d <= '0;
			drain   <= 1'b0;
		end
		else
		begin
			usedw_d <= usedw;
			drain   <= (usedw_d == USEDW_W'(DRAIN_LEVEL) &&
					usedw == USEDW_W'(DRAIN_LEVEL - 1)) ||
					(usedw_d != '0 && empty);
		end
	end

	assert property (@(posedge mclk) disable iff (st_ale)
		(wr_req && full && !fifo_clear) |=> $stable(wr_ptr));

	assert property (@(posedge mclk) disable iff (st_ale)
		(pop && empty && !wr_req && !fifo_clear) |=> $stable(usedw));

endmodule

`default_nettype wire

// ==== hdl/cdc_regs.sv ====
/*
 * CD-controller emulation: HIRQ, HIRQ mask, CR1..CR4 and command pending.
 * Host writes to HIRQ take priority over a console write in the same cycle.
 * Console CR reads return the host response words.
 */
`default_nettype none

module cdc_regs (
	input  logic                              mclk,
	input  logic                              st_ale,
	input  ssm_pkg::ss_bus_t                  ss_bus,
	input  ssm_pkg::st_bus_t                  st_bus,
	input  logic [3:0][ssm_pkg::DATA_W-1:0]   resp,
	output ssm_pkg::cdc_view_t                cdc_view,
	output logic [ssm_pkg::DATA_W-1:0]        cdc_rdata,
	output logic                              cr4_event,
	output logic                              ss_irq
);
	import ssm_pkg::*;

	logic [3:0]             widx;
	logic                   ss_wr;
	logic                   ss_rd;
	logic                   host_set;
	logic                   host_clr;
	logic                   ss_and;
	logic                   mask_wr;
	logic                   cr4_rd;
	logic [DATA_W-1:0]      hirq;
	logic [DATA_W-1:0]      mask;
	logic [3:0][DATA_W-1:0] cr;
	logic                   pending;

	assign widx  = ss_bus.hidx[4:1];
	assign ss_wr = ss_bus.wr && (ss_bus.region == SS_CDC);
	assign ss_rd = ss_bus.rd && (ss_bus.region == SS_CDC);

	// Decoded strobes
	assign host_set  = st_bus.wr && (st_bus.addr == ST_HIRQ);
	assign host_clr  = st_bus.wr && (st_bus.addr == ST_HIRQ_CLR);
	assign ss_and    = ss_wr && (widx == CDC_HIRQ);
	assign mask_wr   = ss_wr && (widx == CDC_MASK);
	assign cr4_event = ss_wr && (widx == CDC_CR4);
	assign cr4_rd    = ss_rd && (widx == CDC_CR4);

	assign ss_irq = |(hirq & mask);

	assign cdc_view = '{cr: cr, hirq: hirq, mask: mask, pending: pending};

	////////////////////
	// HIRQ and status
	////////////////////

	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
		begin
			hirq    <= '0;
			mask    <= '0;
			pending <= 1'b0;
		end
		else
		begin
			if (host_set)
				hirq <= hirq | st_bus.wdata;
			else if (host_clr)
				hirq <= hirq & ~st_bus.wdata;
			else if (ss_and)
				// Console acks by writing zeros
				hirq <= hirq & ss_bus.wdata;
			if (mask_wr)
				mask <= ss_bus.wdata;
			// Reading CR4 ends the command
			if (cr4_rd)
				pending <= 1'b0;
			else if (cr4_event)
				pending <= 1'b1;
		end
	end

	// Command words from the console
	always_ff @(posedge mclk)
	begin
		if (ss_wr)
		begin
			case (cdc_reg_e'(widx))
				CDC_CR1: cr[0] <= ss_bus.wdata;
				CDC_CR2: cr[1] <= ss_bus.wdata;
				CDC_CR3: cr[2] <= ss_bus.wdata;
				CDC_CR4: cr[3] <= ss_bus.wdata;
				default: ;
			endcase
		end
	end

	always_comb
	begin
		case (cdc_reg_e'(widx))
			CDC_HIRQ: cdc_rdata = hirq;
			CDC_MASK: cdc_rdata = mask;
			CDC_CR1:  cdc_rdata = resp[0];
			CDC_CR2:  cdc_rdata = resp[1];
			CDC_CR3:  cdc_rdata = resp[2];
			CDC_CR4:  cdc_rdata = resp[3];
			default:  cdc_rdata = '0;
		endcase
	end

	// A zero mask that stays unwritten keeps the console irq low next cycle
	assert property (@(posedge mclk) disable iff (st_ale)
		(mask == '0 && !mask_wr) |=> !ss_irq);

endmodule

`default_nettype wire

// ==== hdl/ss_sys_regs.sv ====
/*
 * Console system registers: control, command mailbox, shared data, 1 us timer.
 * sys_rdata is a plain mux, and ss_read_port registers the console read.
 */
`default_nettype none

module ss_sys_regs (
	input  logic                          mclk,
	input  logic                          st_ale,
	input  ssm_pkg::ss_bus_t              ss_bus,
	input  ssm_pkg::st_bus_t              st_bus,
	input  logic [ssm_pkg::USEDW_W-1:0]   fifo_usedw,
	input  logic                          fifo_full,
	output ssm_pkg::sys_view_t            sys_view,
	output logic [ssm_pkg::DATA_W-1:0]    sys_rdata,
	output logic                          cmd_event
);
	import ssm_pkg::*;

	logic [3:0]        widx;
	logic              ss_wr;
	logic              tick;
	logic [DATA_W-1:0] ctrl;
	logic [DATA_W-1:0] cmd;
	logic [DATA_W-1:0] data;
	logic [31:0]       timer;
	logic [DIV_W-1:0]  div_cnt;

	assign widx      = ss_bus.hidx[4:1];
	assign ss_wr     = ss_bus.wr && (ss_bus.region == SS_SYS);
	assign cmd_event = ss_wr && (widx == SYS_CMD);
	assign tick      = (div_cnt == DIV_W'(TIMER_DIV - 1));

	assign sys_view = '{ctrl: ctrl, cmd: cmd, data: data};

	////////////////////
	// Mailbox registers
	////////////////////

	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
		begin
			ctrl <= SYS_CTRL_RESET;
			cmd  <= '0;
			data <= '0;
		end
		else
		begin
			if (ss_wr && widx == SYS_CTRL)
				ctrl <= ss_bus.wdata;
			// Host write acknowledges the command
			if (st_bus.wr && st_bus.addr == ST_SS_CMD)
				cmd <= '0;
			else if (cmd_event)
				cmd <= ss_bus.wdata;
			// Console side wins a same-cycle collision
			if (ss_wr && widx == SYS_DATA)
				data <= ss_bus.wdata;
			else if (st_bus.wr && st_bus.addr == ST_SS_DATA)
				data <= st_bus.wdata;
		end
	end

	////////////////////
	// Microsecond timer
	////////////////////

	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
		begin
			div_cnt <= '0;
			timer   <= '0;
		end
		else
		begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (ss_wr && widx == SYS_TIMER)
				timer <= '0;
			else if (tick)
				timer <= timer + 32'd1;
		end
	end

	// Odd half-word picks version and timer low
	always_comb
	begin
		case (sys_reg_e'(widx))
			SYS_ID:    sys_rdata = ss_bus.hidx[0] ? VERSION_WORD : ID_WORD;
			SYS_CTRL:  sys_rdata = ctrl;
			SYS_STAT:  sys_rdata = {4'b0, fifo_full, fifo_usedw};
			SYS_TIMER: sys_rdata = ss_bus.hidx[0] ? timer[15:0] : timer[31:16];
			SYS_CMD:   sys_rdata = cmd;
			SYS_DATA:  sys_rdata = data;
			// FIFO word comes from the read port
			SYS_FIFO:  sys_rdata = '0;
			default:   sys_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/st_host_regs.sv ====
/*
 * Host register file with the three interrupt flags and the host read mux.
 * st_rdata is loaded on a read strobe and holds until the next read.
 * Unmapped offsets read as 0xFFFF.
 */
`default_nettype none

module st_host_regs (
	input  logic                              mclk,
	input  logic                              st_ale,
	input  ssm_pkg::st_bus_t                  st_bus,
	input  ssm_pkg::sys_view_t                sys_view,
	input  ssm_pkg::cdc_view_t                cdc_view,
	input  logic [ssm_pkg::USEDW_W-1:0]       fifo_usedw,
	input  logic                              fifo_full,
	input  logic                              fifo_drain,
	input  logic                              cmd_event,
	input  logic                              cr4_event,
	output logic [ssm_pkg::DATA_W-1:0]        st_rdata,
	output logic                              st_irq,
	output logic [3:0][ssm_pkg::DATA_W-1:0]   resp,
	output logic                              fifo_clear
);
	import ssm_pkg::*;

	logic [DATA_W-1:0] ctrl;
	// Bit 2 FIFO, bit 1 command, bit 0 CDC
	logic [2:0]        flags;
	logic [2:0]        flag_set;
	logic [2:0]        flag_clr;
	logic              stat_wr;
	logic              ctrl_wr;
	logic [DATA_W-1:0] stat_word;
	logic [DATA_W-1:0] fifo_stat;

	assign ctrl_wr  = st_bus.wr && (st_bus.addr == ST_CTRL);
	assign stat_wr  = st_bus.wr && (st_bus.addr == ST_STAT);
	assign flag_set = {fifo_drain, cmd_event, cr4_event};
	// Write-one-to-clear
	assign flag_clr = stat_wr ? st_bus.wdata[2:0] : 3'b000;

	// Enables in control bits 2..0
	assign st_irq     = |(flags & ctrl[2:0]);
	assign fifo_clear = ctrl[8];

	assign stat_word = {1'b0, st_irq, 1'b0, cdc_view.pending, 9'b0, flags};
	assign fifo_stat = {4'b0, fifo_full, fifo_usedw};

	////////////////////
	// Control and flags
	////////////////////

	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
		begin
			ctrl  <= '0;
			flags <= '0;
		end
		else
		begin
			if (ctrl_wr)
				ctrl <= st_bus.wdata;
			// New event beats a clear in the same cycle
			flags <= (flags & ~flag_clr) | flag_set;
		end
	end

	// Response words for the console CR reads
	always_ff @(posedge mclk)
	begin
		if (st_bus.wr)
		begin
			case (st_reg_e'(st_bus.addr))
				ST_CR1:  resp[0] <= st_bus.wdata;
				ST_CR2:  resp[1] <= st_bus.wdata;
				ST_CR3:  resp[2] <= st_bus.wdata;
				ST_CR4:  resp[3] <= st_bus.wdata;
				default: ;
			endcase
		end
	end

	////////////////////
	// Read mux
	////////////////////

	always_ff @(posedge mclk)
	begin
		if (st_bus.rd)
		begin
			case (st_reg_e'(st_bus.addr))
				ST_ID:        st_rdata <= ID_WORD;
				ST_VER:       st_rdata <= VERSION_WORD;
				ST_CTRL:      st_rdata <= ctrl;
				ST_STAT:      st_rdata <= stat_word;
				ST_FIFO_STAT: st_rdata <= fifo_stat;
				ST_SS_CMD:    st_rdata <= sys_view.cmd;
				ST_SS_DATA:   st_rdata <= sys_view.data;
				ST_SS_CTRL:   st_rdata <= sys_view.ctrl;
				ST_RESP1:     st_rdata <= resp[0];
				ST_RESP2:     st_rdata <= resp[1];
				ST_RESP3:     st_rdata <= resp[2];
				ST_RESP4:     st_rdata <= resp[3];
				ST_CR1:       st_rdata <= cdc_view.cr[0];
				ST_CR2:       st_rdata <= cdc_view.cr[1];
				ST_CR3:       st_rdata <= cdc_view.cr[2];
				ST_CR4:       st_rdata <= cdc_view.cr[3];
				ST_HIRQ:      st_rdata <= cdc_view.hirq;
				ST_HIRQ_MASK: st_rdata <= cdc_view.mask;
				// FIFO_WR and HIRQ_CLR are write-only
				default:      st_rdata <= '1;
			endcase
		end
	end

	// An irq edge needs an event or an enable change the cycle before
	assert property (@(posedge mclk) disable iff (st_ale)
		$rose(st_irq) |-> $past(|flag_set || ctrl_wr));

endmodule

`default_nettype wire

// ==== hdl/ssm_pkg.sv ====
/*
 * Widths, register-map encodings and bus structs shared by the bridge core.
 * Both buses arrive as single-cycle strobes on mclk with no handshake.
 * Console addresses are half-word indexes, host addresses are byte offsets.
 */
`default_nettype none

package ssm_pkg;

	////////////////////
	// Sizes
	////////////////////

	localparam int DATA_W      = 16;
	localparam int FIFO_DEPTH  = 1024;
	localparam int USEDW_W     = 11;
	// Pointer wraps at FIFO_DEPTH
	localparam int PTR_W       = USEDW_W - 1;
	localparam int DRAIN_LEVEL = 256;
	// 100 MHz mclk gives a 1 us tick
	localparam int TIMER_DIV   = 100;
	localparam int DIV_W       = $clog2(TIMER_DIV);

	// "SR", then HW1.2 / SW0.3
	localparam logic [DATA_W-1:0] ID_WORD        = 16'h5253;
	localparam logic [DATA_W-1:0] VERSION_WORD   = 16'h1203;
	localparam logic [DATA_W-1:0] SYS_CTRL_RESET = 16'h0100;

	////////////////////
	// Register maps
	////////////////////

	// Host byte offsets
	// Writes to the CR offsets load RESP1..RESP4
	typedef enum logic [7:0] {
		ST_ID        = 8'h00,
		ST_VER       = 8'h02,
		ST_CTRL      = 8'h04,
		ST_STAT      = 8'h06,
		ST_FIFO_WR   = 8'h08,
		ST_FIFO_STAT = 8'h0C,
		ST_SS_CMD    = 8'h10,
		ST_SS_DATA   = 8'h12,
		ST_SS_CTRL   = 8'h14,
		ST_RESP1     = 8'h18,
		ST_RESP2     = 8'h1A,
		ST_RESP3     = 8'h1C,
		ST_RESP4     = 8'h1E,
		ST_CR1       = 8'h20,
		ST_CR2       = 8'h22,
		ST_CR3       = 8'h24,
		ST_CR4       = 8'h26,
		ST_HIRQ      = 8'h28,
		ST_HIRQ_MASK = 8'h2A,
		ST_HIRQ_CLR  = 8'h2C
	} st_reg_e;

	typedef enum logic [1:0] {
		SS_NONE,
		SS_SYS,
		SS_CDC
	} ss_region_e;

	// Console system word indexes
	// Version sits in the odd half of the ID word
	typedef enum logic [3:0] {
		SYS_ID    = 4'd0,
		SYS_CTRL  = 4'd1,
		SYS_STAT  = 4'd2,
		SYS_TIMER = 4'd3,
		SYS_CMD   = 4'd4,
		SYS_DATA  = 4'd5,
		SYS_FIFO  = 4'd6
	} sys_reg_e;

	// CD-controller word indexes
	typedef enum logic [3:0] {
		CDC_FIFO = 4'd0,
		CDC_HIRQ = 4'd2,
		CDC_MASK = 4'd3,
		CDC_CR1  = 4'd6,
		CDC_CR2  = 4'd7,
		CDC_CR3  = 4'd8,
		CDC_CR4  = 4'd9
	} cdc_reg_e;

	////////////////////
	// Bus and views
	////////////////////

	typedef struct packed {
		logic              wr;
		logic              rd;
		logic [7:0]        addr;
		logic [DATA_W-1:0] wdata;
	} st_bus_t;

	typedef struct packed {
		logic              wr;
		logic              rd;
		ss_region_e        region;
		logic [4:0]        hidx;
		logic [DATA_W-1:0] wdata;
	} ss_bus_t;

	// Console system registers as the host sees them
	typedef struct packed {
		logic [DATA_W-1:0] ctrl;
		logic [DATA_W-1:0] cmd;
		logic [DATA_W-1:0] data;
	} sys_view_t;

	// CDC registers as the host sees them, cr[0] is CR1
	typedef struct packed {
		logic [3:0][DATA_W-1:0] cr;
		logic [DATA_W-1:0]      hirq;
		logic [DATA_W-1:0]      mask;
		logic                   pending;
	} cdc_view_t;

endpackage

`default_nettype wire
